/* Makefile */
# Verilator flow for the coupler chain testbench.
TOP := tb_coupler_chain

all: run

obj_dir/V$(TOP): compile.f *.sv
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "NO ERRORS" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* compile.f */
sort_pkg.sv
elem_fifo.sv
coupler.sv
coupler_chain.sv
coupler_checker.sv
tb_coupler_chain.sv

/* coupler.sv */
`timescale 1ns/1ps

module coupler #(
  parameter int IN_W = 32
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [IN_W-1:0]   i_data,
  input  logic              i_enq,
  input  logic              i_deq,
  output logic [2*IN_W-1:0] o_data,
  output logic              o_full,
  output logic              o_empty
);

  localparam int OUT_W = 2 * IN_W;

  typedef enum logic {
    ST_LOW  = 1'b0,
    ST_HIGH = 1'b1
  } state_t;

  state_t           state;
  state_t           state_nxt;

  logic [IN_W-1:0]  in_head;  // head word of the input queue.
  logic             in_empty;
  logic             in_deq;

  logic [OUT_W-1:0] out_word;
  logic             out_full;
  logic             out_enq;

  logic [IN_W-1:0]  low_q;    // key waiting for its partner.
  logic             low_load;
  logic             low_zero;
  logic [IN_W-1:0]  high_slot;

  elem_fifo #(
    .WIDTH (IN_W)
  ) u_in_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_data  (i_data),
    .i_enq   (i_enq),
    .i_deq   (in_deq),
    .o_data  (in_head),
    .o_full  (o_full),
    .o_empty (in_empty)
  );

  elem_fifo #(
    .WIDTH (OUT_W)
  ) u_out_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_data  (out_word),
    .i_enq   (out_enq),
    .i_deq   (i_deq),
    .o_data  (o_data),
    .o_full  (out_full),
    .o_empty (o_empty)
  );

  // a zero low key is the end-of-run sentinel and closes the pair alone.
  assign low_zero  = (low_q == '0);
  assign high_slot = low_zero ? '0 : in_head;
  assign out_word  = {high_slot, low_q}; // high slot in the upper half.

  // the low key is taken only when leaving the LOW state.
  assign low_load = (state == ST_LOW) & in_deq;

  always_comb begin
    state_nxt = state;
    in_deq    = 1'b0;
    out_enq   = 1'b0;
    case (state)
      ST_LOW: begin
        if (!in_empty && !out_full) begin
          in_deq    = 1'b1;
          state_nxt = ST_HIGH;
        end
      end
      ST_HIGH: begin
        if (!out_full && low_zero) begin
          out_enq   = 1'b1; // the next input word stays queued.
          state_nxt = ST_LOW;
        end else if (!out_full && !in_empty) begin
          in_deq    = 1'b1;
          out_enq   = 1'b1;
          state_nxt = ST_LOW;
        end
      end
      default: begin
        state_nxt = ST_LOW;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_LOW;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (low_load) begin
      low_q <= in_head;
    end
  end

endmodule

/* coupler_chain.sv */
`timescale 1ns/1ps

module coupler_chain
  import sort_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [KEY_W-1:0]  i_data,
  input  logic              i_enq,
  input  logic              i_deq,
  output logic [QUAD_W-1:0] o_data,
  output logic              o_full,
  output logic              o_empty
);

  logic [PAIR_W-1:0] s1_data;  // head pair of the first stage.
  logic              s1_empty;
  logic              s2_full;

  // keys to pairs.
  coupler #(
    .IN_W (KEY_W)
  ) u_stage1 (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_data  (i_data),
    .i_enq   (i_enq),
    .i_deq   (~s2_full),  // pull a pair whenever stage 2 has room.
    .o_data  (s1_data),
    .o_full  (o_full),
    .o_empty (s1_empty)
  );

  // pairs to quads.
  coupler #(
    .IN_W (PAIR_W)
  ) u_stage2 (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_data  (s1_data),
    .i_enq   (~s1_empty), // push whenever stage 1 holds a pair.
    .i_deq   (i_deq),
    .o_data  (o_data),
    .o_full  (s2_full),
    .o_empty (o_empty)
  );

endmodule

/* coupler_checker.sv */
`timescale 1ns/1ps

module coupler_checker
  import sort_pkg::*;
(
  input logic               i_clk,
  input logic               i_rst_n,
  input logic               i_full,
  input logic               i_empty,
  input logic [FIFO_AW:0]   i_count,
  input logic [FIFO_AW-1:0] i_wr_ptr,
  input logic [FIFO_AW-1:0] i_rd_ptr
);

  int fail_count = 0; // failed assertions of this queue.

  // the pointers meet exactly when the queue is empty or full.
  a_flags_match_ptrs: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      (i_wr_ptr == i_rd_ptr) == (i_full || i_empty)
  ) else begin
    fail_count++;
    $error("queue flags disagree with its pointers");
  end

  a_count_in_range: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_count <= (FIFO_AW + 1)'(FIFO_DEPTH)
  ) else begin
    fail_count++;
    $error("queue occupancy above its depth");
  end

  // the first edge after reset must still see an empty queue.
  a_empty_after_reset: assert property (
    @(posedge i_clk) $rose(i_rst_n) |-> i_empty
  ) else begin
    fail_count++;
    $error("queue not empty after reset");
  end

endmodule

bind elem_fifo coupler_checker u_chk (
  .i_clk    (i_clk),
  .i_rst_n  (i_rst_n),
  .i_full   (o_full),
  .i_empty  (o_empty),
  .i_count  (count),
  .i_wr_ptr (wr_ptr),
  .i_rd_ptr (rd_ptr)
);

/* coupler_input.txt */
# T name drain mode (0 free, 1 held until o_full, 2 random); W key hex; E quad hex
# G count adds generated keys, their quads come from the pairing rule; X ends a test
T in_order 0
W 00000011
W 00000012
W 00000013
W 00000014
W 00000015
W 00000016
W 00000017
W 00000018
E 00000014000000130000001200000011
E 00000018000000170000001600000015
X
T zero_first 0
W 00000000
W 00000021
W 00000022
W 00000023
W 00000024
E 00000000000000000000000000000000
E 00000024000000230000002200000021
X
T zero_second 0
W 00000031
W 00000000
W 00000032
W 00000033
E 00000033000000320000000000000031
X
T zero_third 0
W 00000041
W 00000042
W 00000000
W 00000043
W 00000044
W 00000045
W 00000046
E 00000000000000000000004200000041
E 00000046000000450000004400000043
X
T zero_fourth 0
W 00000051
W 00000052
W 00000053
W 00000000
W 00000000
E 00000000000000530000005200000051
E 00000000000000000000000000000000
X
T back_pressure 1
G 160
X
T random_stream 2
G 600
X

/* elem_fifo.sv */
`timescale 1ns/1ps

module elem_fifo
  import sort_pkg::*;
#(
  parameter int WIDTH = KEY_W
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_enq,
  input  logic             i_deq,
  output logic [WIDTH-1:0] o_data,
  output logic             o_full,
  output logic             o_empty
);

  logic [WIDTH-1:0]   mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               wr_en;
  logic               rd_en;

  // the flags come straight from the registered occupancy.
  assign o_full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign o_empty = (count == '0);

  assign wr_en = i_enq & ~o_full;  // an enqueue while full is dropped.
  assign rd_en = i_deq & ~o_empty; // a dequeue while empty is ignored.

  // the head word is always on the output.
  assign o_data = mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + FIFO_AW'(1); // wraps at the depth.
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + FIFO_AW'(1);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10: begin
          count <= count + (FIFO_AW + 1)'(1);
        end
        2'b01: begin
          count <= count - (FIFO_AW + 1)'(1);
        end
        default: begin
          count <= count; // both or neither leaves the occupancy alone.
        end
      endcase
    end
  end

endmodule

/* sort_pkg.sv */
package sort_pkg;

  // key and record widths along the widening path.
  localparam int KEY_W  = 32;         // one sorted key.
  localparam int PAIR_W = 2 * KEY_W;  // two keys after the first coupler.
  localparam int QUAD_W = 2 * PAIR_W; // four keys after the second coupler.

  // every queue in the datapath has the same depth.
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // pointer width.

endpackage

/* tb_coupler_chain.sv */
`timescale 1ns/1ps

module tb_coupler_chain
  import sort_pkg::*;
();

  localparam int    CLK_PERIOD = 4;
  localparam int    SEED       = 72;
  localparam string DATA_FILE  = "coupler_input.txt";
  localparam int    IDLE_LIMIT = 64; // quiet cycles that close a test.

  logic              i_clk;
  logic              i_rst_n;
  logic [KEY_W-1:0]  i_data;
  logic              i_enq;
  logic              i_deq;
  logic [QUAD_W-1:0] o_data;
  logic              o_full;
  logic              o_empty;

  logic [KEY_W-1:0]  key_q[$];
  logic [QUAD_W-1:0] exp_q[$];
  string             test_name;
  int                drain_mode; // 0 free, 1 held until full, 2 random.
  bit                drv_done;
  bit                full_seen;
  int                err_count;
  int                pass_tests;
  int                fail_tests;
  int                quads_seen;

  coupler_chain u_dut (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_data  (i_data),
    .i_enq   (i_enq),
    .i_deq   (i_deq),
    .o_data  (o_data),
    .o_full  (o_full),
    .o_empty (o_empty)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  task automatic check_quad(input string name, input logic [QUAD_W-1:0] exp,
                            input logic [QUAD_W-1:0] act);
    if (act !== exp) begin
      err_count++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input string flag, input logic exp,
                            input logic act);
    if (act !== exp) begin
      err_count++;
      $display("ERR %s %s expected %b actual %b", name, flag, exp, act);
    end
  endtask

  task automatic report_test(input int errs_before);
    if (err_count == errs_before) begin
      pass_tests++;
      $display("test %s passed, %0d quads", test_name, quads_seen);
    end else begin
      fail_tests++;
      $display("test %s failed, %0d errors", test_name, err_count - errs_before);
    end
  endtask

  // keys pair low first, then the pairs pair the same way.
  task automatic model_stream(output bit dangling);
    logic [PAIR_W-1:0] pairs[$];
    logic [KEY_W-1:0]  low_key;
    logic [PAIR_W-1:0] low_pair;
    bit                have_key;
    bit                have_pair;
    have_key  = 1'b0;
    have_pair = 1'b0;
    low_key   = '0;
    low_pair  = '0;
    exp_q.delete();
    foreach (key_q[i]) begin
      if (have_key) begin
        pairs.push_back({key_q[i], low_key});
        have_key = 1'b0;
      end else if (key_q[i] == '0) begin
        pairs.push_back('0); // a sentinel closes its pair alone.
      end else begin
        low_key  = key_q[i];
        have_key = 1'b1;
      end
    end
    foreach (pairs[i]) begin
      if (have_pair) begin
        exp_q.push_back({pairs[i], low_pair});
        have_pair = 1'b0;
      end else if (pairs[i] == '0) begin
        exp_q.push_back('0);
      end else begin
        low_pair  = pairs[i];
        have_pair = 1'b1;
      end
    end
    dangling = have_key | have_pair;
  endtask

  // ascending keys with sentinels, padded so that nothing stays in the pipeline.
  task automatic gen_keys(input int count);
    logic [KEY_W-1:0] key;
    bit               dangling;
    key = '0;
    repeat (count) begin
      if (drain_mode != 1 && $urandom_range(0, 7) == 0) begin
        key = '0;
      end else begin
        key = key + KEY_W'($urandom_range(1, 255));
      end
      key_q.push_back(key);
    end
    model_stream(dangling);
    while (dangling) begin
      key_q.push_back('0);
      model_stream(dangling);
    end
  endtask

  task automatic drive_keys();
    while (key_q.size() > 0) begin
      @(posedge i_clk);
      #1;
      if (!o_full && (drain_mode != 2 || $urandom_range(0, 3) != 0)) begin
        i_enq  = 1'b1;
        i_data = key_q.pop_front();
      end else begin
        i_enq = 1'b0;
      end
    end
    @(posedge i_clk);
    #1;
    i_enq    = 1'b0;
    drv_done = 1'b1;
  endtask

  task automatic collect_quads();
    int idle;
    bit take;
    idle       = 0;
    quads_seen = 0;
    while (!(drv_done && idle >= IDLE_LIMIT)) begin
      @(posedge i_clk);
      #1;
      if (o_full) begin
        full_seen = 1'b1;
      end
      case (drain_mode)
        1:       take = full_seen || drv_done;
        2:       take = ($urandom_range(0, 2) != 0);
        default: take = 1'b1;
      endcase
      if (take && !o_empty) begin
        i_deq = 1'b1;
        idle  = 0;
        quads_seen++;
        if (exp_q.size() == 0) begin
          err_count++;
          $display("%s: unexpected extra quad %h", test_name, o_data);
        end else begin
          check_quad(test_name, exp_q.pop_front(), o_data);
        end
      end else begin
        i_deq = 1'b0;
        idle++;
      end
    end
    i_deq = 1'b0;
  endtask

  task automatic run_test();
    int errs_before;
    errs_before = err_count;
    drv_done    = 1'b0;
    full_seen   = 1'b0;
    fork
      drive_keys();
      collect_quads();
    join
    if (exp_q.size() != 0) begin
      err_count++;
      $display("%s: %0d expected quads never came out", test_name, exp_q.size());
    end
    if (drain_mode == 1 && !full_seen) begin
      err_count++;
      $display("%s: o_full never rose while the output was held", test_name);
    end
    report_test(errs_before);
    key_q.delete();
    exp_q.delete();
  endtask

  function automatic int count_keys();
    int    fd;
    int    n;
    int    count;
    string line;
    n     = 0;
    count = 0;
    fd    = $fopen(DATA_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] == "W") begin
          n++;
        end else if (line.len() > 0 && line[0] == "G") begin
          void'($sscanf(line, "G %d", count));
          n += count;
        end
      end
      $fclose(fd);
    end
    return n;
  endfunction

  function automatic int assertion_failures();
    return u_dut.u_stage1.u_in_fifo.u_chk.fail_count
         + u_dut.u_stage1.u_out_fifo.u_chk.fail_count
         + u_dut.u_stage2.u_in_fifo.u_chk.fail_count
         + u_dut.u_stage2.u_out_fifo.u_chk.fail_count;
  endfunction

  initial begin
    int limit;
    limit = 200 * count_keys() + 1000; // cycles allowed for the whole file.
    repeat (limit) @(posedge i_clk);
    $display("timeout: run stopped after %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int                fd;
    int                count;
    int                errs_before;
    string             line;
    logic [KEY_W-1:0]  key;
    logic [QUAD_W-1:0] quad;
    void'($urandom(SEED));
    i_rst_n    = 1'b0;
    i_data     = '0;
    i_enq      = 1'b0;
    i_deq      = 1'b0;
    err_count  = 0;
    pass_tests = 0;
    fail_tests = 0;
    quads_seen = 0;
    drain_mode = 0;
    repeat (10) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    test_name   = "reset_state";
    errs_before = err_count;
    check_flag(test_name, "o_empty", 1'b1, o_empty);
    check_flag(test_name, "o_full", 1'b0, o_full);
    report_test(errs_before);

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      err_count++;
      $display("cannot open the data file %s", DATA_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0) begin
          case (line[0])
            "T": void'($sscanf(line, "T %s %d", test_name, drain_mode));
            "W": begin
              void'($sscanf(line, "W %h", key));
              key_q.push_back(key);
            end
            "E": begin
              void'($sscanf(line, "E %h", quad));
              exp_q.push_back(quad);
            end
            "G": begin
              void'($sscanf(line, "G %d", count));
              gen_keys(count);
            end
            "X": run_test();
            default: ; // comments and blank lines.
          endcase
        end
      end
      $fclose(fd);
    end

    if (assertion_failures() != 0) begin
      err_count += assertion_failures();
      $display("%0d queue assertions failed during the run", assertion_failures());
    end
    $display("tests passed: %0d, failed: %0d", pass_tests, fail_tests);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
